// File: source/rx_types_pkg.sv
// rx buffer datapath types: frame words, lengths and drain engine index
`default_nettype none

package rx_types_pkg;

    typedef logic [63:0] word_t;    // one frame data word
    typedef logic [15:0] len_t;     // frame length in words
    typedef logic        eng_t;     // drain engine index

endpackage

`default_nettype wire

// File: source/rx_ctrl_pkg.sv
// rx buffer control encodings for slot and drain engine state machines
`default_nettype none

package rx_ctrl_pkg;

    typedef enum logic [1:0] {SLOT_EMPTY, SLOT_FILLING, SLOT_READY, SLOT_DRAINING} slot_state_t;

    typedef enum logic [1:0] {ENG_IDLE, ENG_CLAIM, ENG_READ, ENG_FINISH} eng_state_t;

endpackage

`default_nettype wire

// File: source/rd_port_if.sv
// read port request channel between one drain engine and the read arbiter
`timescale 1ns/1ps
`default_nettype none

interface rd_port_if import rx_types_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) ();

    logic                  req;     // held until grant
    logic [ADDR_WIDTH-1:0] addr;    // full ram address, msb is the slot
    logic                  grant;   // read accepted this cycle
    word_t                 rdata;
    logic                  rvalid;  // two cycles after grant

    modport requester (output req, output addr,
                       input grant, input rdata, input rvalid);

    modport arbiter (input req, input addr,
                     output grant, output rdata, output rvalid);

endinterface

`default_nettype wire

// File: source/rx_buff.sv
// two-bank frame ram with registered write and two-stage registered read
`timescale 1ns/1ps
`default_nettype none

module rx_buff import rx_types_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire logic                  clk,
    input  wire logic [ADDR_WIDTH-1:0] wr_addr,
    input  wire word_t                 wr_data,
    input  wire logic                  wr_en,
    input  wire logic [ADDR_WIDTH-1:0] rd_addr,
    output      word_t                 rd_data
);

    localparam int BANK_DEPTH = 2 ** (ADDR_WIDTH - 1);

    logic [ADDR_WIDTH-1:0] wr_addr_q;
    word_t                 wr_data_q;
    logic                  wr_en_q;
    logic [ADDR_WIDTH-1:0] rd_addr_q;

    word_t bank_0 [BANK_DEPTH];    // slot 0
    word_t bank_1 [BANK_DEPTH];    // slot 1

    ////////////////////////////////////////////////////////////////////////////
    // write side, lands one cycle after the input register
    always_ff @(posedge clk) begin
        wr_addr_q <= wr_addr;
        wr_data_q <= wr_data;
        wr_en_q   <= wr_en;
        if (wr_en_q) begin
            if (!wr_addr_q[ADDR_WIDTH-1]) bank_0[wr_addr_q[ADDR_WIDTH-2:0]] <= wr_data_q;
            else                          bank_1[wr_addr_q[ADDR_WIDTH-2:0]] <= wr_data_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read side, address reg then data reg
    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;
        if (!rd_addr_q[ADDR_WIDTH-1]) rd_data <= bank_0[rd_addr_q[ADDR_WIDTH-2:0]];
        else                          rd_data <= bank_1[rd_addr_q[ADDR_WIDTH-2:0]];
    end

endmodule

`default_nettype wire

// File: source/rx_frame_writer.sv
// frame writer: places incoming words in a free slot, commits or drops the frame
`timescale 1ns/1ps
`default_nettype none

module rx_frame_writer import rx_types_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire word_t                 in_data,
    input  wire logic                  in_valid,
    input  wire logic                  in_last,
    output      logic                  claim_wr,
    input  wire logic                  wr_slot_ok,
    input  wire logic                  wr_slot,
    output      logic                  commit,
    output      len_t                  commit_len,
    output      logic                  abort,
    output      logic [ADDR_WIDTH-1:0] wr_addr,
    output      word_t                 wr_data,
    output      logic                  wr_en,
    output      logic                  drop
);

    localparam len_t SLOT_WORDS = len_t'(2 ** (ADDR_WIDTH - 1));

    logic filling;       // frame in progress, slot held
    logic discarding;    // swallowing rest of a dropped frame
    logic cur_slot;
    len_t cnt;           // words written so far
    logic commit_d;      // first commit delay stage
    len_t len_d;
    logic start;
    logic full;

    assign start    = in_valid && !filling && !discarding;    // first word of a frame
    assign claim_wr = start;
    assign full     = (cnt == SLOT_WORDS);
    assign abort    = filling && in_valid && full;             // oversized, give slot back
    assign wr_data  = in_data;

    // slot base plus word count
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = {cur_slot, cnt[ADDR_WIDTH-2:0]};
        if (start) begin
            wr_en   = wr_slot_ok;
            wr_addr = {wr_slot, {(ADDR_WIDTH-1){1'b0}}};
        end else if (filling && in_valid && !full) begin
            wr_en = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            filling    <= 1'b0;
            discarding <= 1'b0;
            cur_slot   <= 1'b0;
            cnt        <= '0;
            commit_d   <= 1'b0;
            commit     <= 1'b0;
            drop       <= 1'b0;
        end else begin
            drop     <= 1'b0;
            commit_d <= 1'b0;
            commit   <= commit_d;    // 2 cycles after last word, word is in ram by then
            if (start) begin
                if (wr_slot_ok) begin
                    cur_slot <= wr_slot;
                    cnt      <= len_t'(1);
                    filling  <= !in_last;
                    commit_d <= in_last;    // single word frame
                end else begin
                    drop       <= 1'b1;    // no free slot
                    discarding <= !in_last;
                end
            end else if (filling && in_valid) begin
                if (full) begin
                    drop       <= 1'b1;
                    filling    <= 1'b0;
                    discarding <= !in_last;
                end else begin
                    cnt <= cnt + 1'b1;
                    if (in_last) begin
                        filling  <= 1'b0;
                        commit_d <= 1'b1;
                    end
                end
            end else if (discarding && in_valid && in_last) begin
                discarding <= 1'b0;
            end
        end
    end

    // length rides beside the commit delay
    always_ff @(posedge clk) begin
        if (wr_en && in_last) len_d <= start ? len_t'(1) : cnt + 1'b1;
        commit_len <= len_d;
    end

endmodule

`default_nettype wire

// File: source/rx_slot_manager.sv
// slot manager: state and length of both slots, hands ready frames out oldest first
`timescale 1ns/1ps
`default_nettype none

module rx_slot_manager import rx_types_pkg::*, rx_ctrl_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic claim_wr,
    output      logic wr_slot_ok,
    output      logic wr_slot,
    input  wire logic commit,
    input  wire len_t commit_len,
    input  wire logic abort,
    output      logic frame_avail,
    output      logic frame_slot,
    output      len_t frame_len,
    input  wire logic take_0,
    input  wire logic take_1,
    input  wire logic release_0,
    input  wire logic release_1,
    output      eng_t taken_by
);

    slot_state_t           state [2];
    logic [ADDR_WIDTH-1:0] len_q [2];    // a full slot needs ADDR_WIDTH bits
    logic                  held  [2];    // slot held by each engine
    logic                  oldest;       // ready slot committed first
    logic                  last_claim;   // slot the writer claimed most recently
    logic                  commit_slot;
    logic                  take_any;

    assign wr_slot_ok = (state[0] == SLOT_EMPTY) || (state[1] == SLOT_EMPTY);
    assign wr_slot    = (state[0] != SLOT_EMPTY);    // lowest empty slot

    // two filling slots means the older claim is the one finishing
    assign commit_slot = (state[0] == SLOT_FILLING && state[1] == SLOT_FILLING) ?
                         !last_claim : (state[1] == SLOT_FILLING);

    assign frame_avail = (state[0] == SLOT_READY) || (state[1] == SLOT_READY);
    assign frame_slot  = (state[0] == SLOT_READY && state[1] == SLOT_READY) ?
                         oldest : (state[1] == SLOT_READY);
    assign frame_len   = len_t'(len_q[frame_slot]);
    assign take_any    = frame_avail && (take_0 || take_1);    // engine 0 wins a tie

    always_ff @(posedge clk) begin
        if (reset) begin
            state[0]   <= SLOT_EMPTY;
            state[1]   <= SLOT_EMPTY;
            oldest     <= 1'b0;
            last_claim <= 1'b0;
            taken_by   <= eng_t'(0);
        end else begin
            if (claim_wr && wr_slot_ok) begin
                state[wr_slot] <= SLOT_FILLING;
                last_claim     <= wr_slot;
            end
            if (commit) begin
                state[commit_slot] <= SLOT_READY;
                if (state[!commit_slot] != SLOT_READY) oldest <= commit_slot;
            end
            if (abort) state[last_claim] <= SLOT_EMPTY;    // oversized frame
            if (take_any) begin
                state[frame_slot] <= SLOT_DRAINING;
                taken_by          <= take_0 ? eng_t'(0) : eng_t'(1);
            end
            if (release_0) state[held[0]] <= SLOT_EMPTY;
            if (release_1) state[held[1]] <= SLOT_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (commit) len_q[commit_slot] <= commit_len[ADDR_WIDTH-1:0];
        if (take_any) held[take_0 ? 0 : 1] <= frame_slot;
    end

endmodule

`default_nettype wire

// File: source/rd_port_arbiter.sv
// round-robin arbiter sharing the ram read port between the two drain engines
`timescale 1ns/1ps
`default_nettype none

module rd_port_arbiter import rx_types_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    rd_port_if.arbiter                 port_0,
    rd_port_if.arbiter                 port_1,
    output      logic [ADDR_WIDTH-1:0] rd_addr,
    input  wire word_t                 rd_data
);

    eng_t       last_win;    // winner of the previous grant
    logic       gnt_0;
    logic       gnt_1;
    logic [1:0] vld_q;       // read in flight, stage 1 and 2
    eng_t       win_q [2];   // winner beside each ram read register

    ////////////////////////////////////////////////////////////////////////////
    // grant, engine 0 wins unless it won last time and 1 is waiting
    assign gnt_0 = port_0.req && (!port_1.req || last_win == eng_t'(1));
    assign gnt_1 = port_1.req && !gnt_0;

    assign port_0.grant = gnt_0;
    assign port_1.grant = gnt_1;
    assign rd_addr      = gnt_1 ? port_1.addr : port_0.addr;

    ////////////////////////////////////////////////////////////////////////////
    // return path, data is common and rvalid steers it
    assign port_0.rdata  = rd_data;
    assign port_1.rdata  = rd_data;
    assign port_0.rvalid = vld_q[1] && (win_q[1] == eng_t'(0));
    assign port_1.rvalid = vld_q[1] && (win_q[1] == eng_t'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            last_win <= eng_t'(1);    // engine 0 first after reset
            vld_q    <= 2'b00;
            win_q[0] <= eng_t'(0);
            win_q[1] <= eng_t'(0);
        end else begin
            if (gnt_0 || gnt_1) last_win <= eng_t'(gnt_1);
            vld_q    <= {vld_q[0], gnt_0 || gnt_1};
            win_q[0] <= eng_t'(gnt_1);
            win_q[1] <= win_q[0];
        end
    end

endmodule

`default_nettype wire

// File: source/rx_drain_engine.sv
// drain engine: claims a ready slot, reads it through the arbiter and streams it out
`timescale 1ns/1ps
`default_nettype none

module rx_drain_engine import rx_types_pkg::*, rx_ctrl_pkg::*; #(
    parameter int ADDR_WIDTH = 10,
    parameter int ENGINE_ID  = 0
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      frame_avail,
    input  wire logic      frame_slot,
    input  wire len_t      frame_len,
    input  wire eng_t      taken_by,
    output      logic      take,
    output      logic      release_slot,
    rd_port_if.requester   rd,
    output      word_t     out_data,
    output      logic      out_valid,
    output      logic      out_last
);

    eng_state_t state;
    logic       slot_q;     // slot being drained
    len_t       len_q;
    len_t       issued;     // reads granted
    len_t       recv;       // words returned
    logic       last_word;

    assign take         = (state == ENG_IDLE) && frame_avail;
    assign release_slot = (state == ENG_FINISH);    // one cycle after out_last

    // one read per grant until every address went out
    assign rd.req  = (state == ENG_READ) && (issued != len_q);
    assign rd.addr = {slot_q, issued[ADDR_WIDTH-2:0]};

    assign last_word = (recv == len_q - 1'b1);
    assign out_data  = rd.rdata;
    assign out_valid = (state == ENG_READ) && rd.rvalid;
    assign out_last  = out_valid && last_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ENG_IDLE;
            issued <= '0;
            recv   <= '0;
        end else begin
            case (state)
                ENG_IDLE: if (frame_avail) state <= ENG_CLAIM;
                ENG_CLAIM: begin
                    issued <= '0;
                    recv   <= '0;
                    // lost the tie to the other engine, try again
                    state  <= (taken_by == eng_t'(ENGINE_ID)) ? ENG_READ : ENG_IDLE;
                end
                ENG_READ: begin
                    if (rd.grant) issued <= issued + 1'b1;
                    if (rd.rvalid) begin
                        recv <= recv + 1'b1;
                        if (last_word) state <= ENG_FINISH;
                    end
                end
                default: state <= ENG_IDLE;    // finish, slot released
            endcase
        end
    end

    // frame info is only valid in the take cycle
    always_ff @(posedge clk) begin
        if (take) begin
            slot_q <= frame_slot;
            len_q  <= frame_len;
        end
    end

endmodule

`default_nettype wire

// File: source/rx_buffer_top.sv
// rx frame buffer top: two-slot ram, writer, slot manager and two drain engines
`timescale 1ns/1ps
`default_nettype none

module rx_buffer_top import rx_types_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire word_t in_data,
    input  wire logic  in_valid,
    input  wire logic  in_last,
    output      word_t out_data_0,
    output      logic  out_valid_0,
    output      logic  out_last_0,
    output      word_t out_data_1,
    output      logic  out_valid_1,
    output      logic  out_last_1,
    output      logic  drop
);

    logic claim_wr, wr_slot_ok, wr_slot, commit, abort, wr_en;
    len_t commit_len, frame_len;
    logic [ADDR_WIDTH-1:0] wr_addr, rd_addr;
    word_t wr_data, rd_data;
    logic frame_avail, frame_slot, take_0, take_1, release_0, release_1;
    eng_t taken_by;

    rd_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) rd_if_0 ();
    rd_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) rd_if_1 ();

    rx_buff #(.ADDR_WIDTH(ADDR_WIDTH)) u_buff (.clk, .wr_addr, .wr_data, .wr_en,
        .rd_addr, .rd_data);

    rx_frame_writer #(.ADDR_WIDTH(ADDR_WIDTH)) u_writer (.clk, .reset, .in_data, .in_valid,
        .in_last, .claim_wr, .wr_slot_ok, .wr_slot, .commit, .commit_len, .abort,
        .wr_addr, .wr_data, .wr_en, .drop);

    rx_slot_manager #(.ADDR_WIDTH(ADDR_WIDTH)) u_slots (.clk, .reset, .claim_wr, .wr_slot_ok,
        .wr_slot, .commit, .commit_len, .abort, .frame_avail, .frame_slot, .frame_len,
        .take_0, .take_1, .release_0, .release_1, .taken_by);

    rd_port_arbiter #(.ADDR_WIDTH(ADDR_WIDTH)) u_arb (.clk, .reset, .port_0(rd_if_0),
        .port_1(rd_if_1), .rd_addr, .rd_data);

    rx_drain_engine #(.ADDR_WIDTH(ADDR_WIDTH), .ENGINE_ID(0)) u_eng_0 (.clk, .reset,
        .frame_avail, .frame_slot, .frame_len, .taken_by, .take(take_0),
        .release_slot(release_0), .rd(rd_if_0), .out_data(out_data_0),
        .out_valid(out_valid_0), .out_last(out_last_0));

    rx_drain_engine #(.ADDR_WIDTH(ADDR_WIDTH), .ENGINE_ID(1)) u_eng_1 (.clk, .reset,
        .frame_avail, .frame_slot, .frame_len, .taken_by, .take(take_1),
        .release_slot(release_1), .rd(rd_if_1), .out_data(out_data_1),
        .out_valid(out_valid_1), .out_last(out_last_1));

endmodule

`default_nettype wire

// File: bench/rx_buffer_tb.sv
// rx frame buffer testbench with a frame table, two output scoreboards and a watchdog
`timescale 1ns/1ps
`default_nettype none

module rx_buffer_tb import rx_types_pkg::*;;

    localparam int ADDR_WIDTH = 6;     // 32-word slots
    localparam int NUM_ROWS   = 12;

    typedef struct packed {
        logic [31:0] id;
        logic [15:0] len;              // words
        logic [15:0] gap;              // idle cycles after the frame
        logic        drop;             // frame must never come out
    } frame_row_t;

    // id, length, gap, dropped
    frame_row_t rows [NUM_ROWS] = '{
        '{32'd1,  16'd1,  16'd60,  1'b0},    // single word
        '{32'd2,  16'd8,  16'd60,  1'b0},
        '{32'd3,  16'd32, 16'd80,  1'b0},    // exactly one slot
        '{32'd4,  16'd40, 16'd40,  1'b1},    // oversized
        '{32'd5,  16'd6,  16'd60,  1'b0},    // kept after the oversized one
        '{32'd6,  16'd33, 16'd40,  1'b1},    // one word too long
        '{32'd7,  16'd30, 16'd0,   1'b0},    // slot stays held for the next two
        '{32'd8,  16'd3,  16'd0,   1'b0},    // takes the other slot
        '{32'd9,  16'd5,  16'd100, 1'b1},    // both slots busy at its start
        '{32'd10, 16'd30, 16'd0,   1'b0},    // long pair drained side by side
        '{32'd11, 16'd12, 16'd120, 1'b0},
        '{32'd12, 16'd4,  16'd20,  1'b0}
    };

    logic  clk;
    logic  reset;
    word_t in_data;
    logic  in_valid;
    logic  in_last;
    word_t out_data_0;
    logic  out_valid_0;
    logic  out_last_0;
    word_t out_data_1;
    logic  out_valid_1;
    logic  out_last_1;
    logic  drop;

    word_t scramble_mask [64];         // per word index
    int    pending_ids [$];            // kept frames not yet started on an output
    logic  in_frame [2] = '{1'b0, 1'b0};
    int    cur_id [2];
    int    cur_idx [2];
    int    cur_len [2];
    int    drops_seen     = 0;
    int    drops_expected = 0;
    int    kept_count     = 0;
    int    frames_done    = 0;
    logic  overlap_seen   = 1'b0;      // both outputs mid-frame at once
    logic  quiet_window   = 1'b1;      // reset and the cycles right after
    logic  sampling       = 1'b0;      // first reset edge has reached the flops

    rx_buffer_top #(.ADDR_WIDTH(ADDR_WIDTH)) uut (.clk, .reset, .in_data, .in_valid,
        .in_last, .out_data_0, .out_valid_0, .out_last_0, .out_data_1, .out_valid_1,
        .out_last_1, .drop);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // expected values and error exits

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // frame id up top and word index below, then scrambled
    function automatic word_t word_value(input int id, input int k);
        return {id, k} ^ scramble_mask[k[5:0]];
    endfunction

    function automatic int length_of(input int id);
        int len;
        len = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].id == id) len = rows[i].len;
        end
        return len;
    endfunction

    function automatic int watchdog_cycles();
        int words;
        words = 0;
        for (int i = 0; i < NUM_ROWS; i++) words += rows[i].len;
        return words * 40 + 500;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_bad_value(input string msg);
        stop_run($sformatf("MISMATCH at %0t: %s", $time, msg));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // scoreboard sampled on the falling edge

    task automatic check_quiet_outputs();
        assert (!out_valid_0 && !out_valid_1 && !out_last_0 && !out_last_1 && !drop)
            else report_bad_value("output active during or right after reset");
    endtask

    task automatic check_output(input int o, input word_t data, input logic valid,
                                input logic last);
        int found;
        found = -1;
        if (!valid) begin
            assert (!last) else report_bad_value($sformatf("out_last_%0d without valid", o));
            return;
        end
        if (!in_frame[o]) begin    // new frame is looked up by its first word
            foreach (pending_ids[i]) begin
                if (word_value(pending_ids[i], 0) == data) found = i;
            end
            assert (found >= 0) else report_bad_value(
                $sformatf("output %0d starts unknown, dropped or repeated frame %h", o, data));
            cur_id[o]   = pending_ids[found];
            cur_len[o]  = length_of(cur_id[o]);
            cur_idx[o]  = 0;
            in_frame[o] = 1'b1;
            pending_ids.delete(found);
        end
        assert (data == word_value(cur_id[o], cur_idx[o])) else report_bad_value(
            $sformatf("frame %0d word %0d on output %0d is %h, expected %h", cur_id[o],
                      cur_idx[o], o, data, word_value(cur_id[o], cur_idx[o])));
        assert (last == (cur_idx[o] == cur_len[o] - 1)) else report_bad_value(
            $sformatf("frame %0d word %0d on output %0d has out_last %b", cur_id[o],
                      cur_idx[o], o, last));
        cur_idx[o]++;
        if (last) begin
            in_frame[o] = 1'b0;
            frames_done++;
        end
    endtask

    always @(negedge clk) begin
        if (sampling) begin
            if (quiet_window) check_quiet_outputs();
            if (drop) begin
                drops_seen++;
                assert (drops_seen <= drops_expected) else report_bad_value(
                    $sformatf("drop pulse %0d, only %0d expected", drops_seen,
                              drops_expected));
            end
            check_output(0, out_data_0, out_valid_0, out_last_0);
            check_output(1, out_data_1, out_valid_1, out_last_1);
            if (in_frame[0] && in_frame[1]) overlap_seen = 1'b1;
        end
    end

    // watchdog
    initial begin
        repeat (watchdog_cycles()) @(posedge clk);
        stop_run($sformatf("timeout after %0d cycles, %0d of %0d frames delivered",
                           watchdog_cycles(), frames_done, kept_count));
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        logic [31:0] seed_state;
        int          i;
        int          r;
        int          k;
        seed_state = 32'ha883_d5e0;
        for (i = 0; i < 64; i++) begin
            seed_state               = lcg_next(seed_state);
            scramble_mask[i][63:32] = seed_state;
            seed_state               = lcg_next(seed_state);
            scramble_mask[i][31:0]  = seed_state;
        end
        reset    = 1'b1;
        in_data  = '0;
        in_valid = 1'b0;
        in_last  = 1'b0;
        for (r = 0; r < NUM_ROWS; r++) begin    // expected outcome per row
            if (rows[r].drop) begin
                drops_expected++;
            end else begin
                pending_ids.push_back(rows[r].id);
                kept_count++;
            end
        end

        @(posedge clk);
        sampling <= 1'b1;
        repeat (15) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        quiet_window <= 1'b0;

        for (r = 0; r < NUM_ROWS; r++) begin
            for (k = 0; k < rows[r].len; k++) begin
                @(posedge clk);
                in_data  <= word_value(rows[r].id, k);
                in_valid <= 1'b1;
                in_last  <= (k == rows[r].len - 1);
            end
            if (rows[r].gap != 0) begin    // with zero gap the next frame follows at once
                @(posedge clk);
                in_data  <= '0;
                in_valid <= 1'b0;
                in_last  <= 1'b0;
                repeat (rows[r].gap - 1) @(posedge clk);
            end
        end

        // wait for every kept frame and then a quiet tail for strays
        while (pending_ids.size() != 0 || in_frame[0] || in_frame[1]) @(negedge clk);
        repeat (50) @(negedge clk);

        assert (drops_seen == drops_expected) else report_bad_value(
            $sformatf("%0d drop pulses, expected %0d", drops_seen, drops_expected));
        assert (overlap_seen)
            else stop_run("the two outputs never carried frames at the same time");
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
source/rx_types_pkg.sv
source/rx_ctrl_pkg.sv
source/rd_port_if.sv
source/rx_buff.sv
source/rx_frame_writer.sv
source/rx_slot_manager.sv
source/rd_port_arbiter.sv
source/rx_drain_engine.sv
source/rx_buffer_top.sv
bench/rx_buffer_tb.sv

// File: Bender.yml
package:
  name: rx_buffer

sources:
  - source/rx_types_pkg.sv
  - source/rx_ctrl_pkg.sv
  - source/rd_port_if.sv
  - source/rx_buff.sv
  - source/rx_frame_writer.sv
  - source/rx_slot_manager.sv
  - source/rd_port_arbiter.sv
  - source/rx_drain_engine.sv
  - source/rx_buffer_top.sv

  - target: test
    files:
      - bench/rx_buffer_tb.sv
